/* hw/xotrPkg.sv */
// shared widths, enums and structs for the ED 01xxx10x execution unit, used by RTL and testbench
`default_nettype none

package xotrPkg;

    // ****************************************
    // constants
    // ****************************************

    localparam int StepWidth = 5;                 // same width as XPT
    localparam logic [2:0] RetiField = 3'b001;    // opcode bits 5:3 of RETI

    localparam logic [StepWidth-1:0] StepFirst = '0;
    localparam logic [StepWidth-1:0] StepSecond = StepWidth'(1);

    // ****************************************
    // enums
    // ****************************************

    typedef enum logic [1:0] {
        OpNeg,      // 01xxx100
        OpRet,      // 01xxx101, RETN or RETI
        OpNone      // anything else, one empty step
    } xotrOpE;

    typedef enum logic [1:0] {
        StIdle,
        StExec,
        StDone
    } xotrStateE;

    // ****************************************
    // structs
    // ****************************************

    typedef struct packed {
        logic negWrite;     // A and F take the NEG result
        logic popPcLow;
        logic popPcHigh;
        logic incSp;
        logic restoreIff;   // IFF1 <= IFF2
        logic retiAck;      // pulse to the interrupt controller
        logic lastStep;
    } xotrCtrlS;

    typedef struct packed {
        logic [7:0]  a;
        logic [15:0] sp;
        logic [15:0] pc;
        logic        iff2;
    } xotrLoadS;

    // flag byte in hardware bit order, 7 down to 0
    typedef struct packed {
        logic s;
        logic z;
        logic b5;
        logic h;
        logic b3;
        logic pv;
        logic n;
        logic c;
    } xotrFlagS;

    typedef struct packed {
        logic [7:0]  a;
        xotrFlagS    f;
        logic [15:0] pc;
        logic [15:0] sp;
        logic        iff1;
        logic        iff2;
    } xotrRegsS;

endpackage

`default_nettype wire

/* hw/xotrStepCounter.sv */
// execution step counter; the decoder reads its value to know which step is running
`timescale 1ns/1ps
`default_nettype none

module xotrStepCounter (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire logic                         clear,    // wins over advance
    input  wire logic                         advance,
    output      logic [xotrPkg::StepWidth-1:0] step
);

    logic [xotrPkg::StepWidth-1:0] stepNext;

    always_comb begin
        stepNext = step;
        if (clear) begin
            stepNext = '0;
        end else if (advance) begin
            stepNext = step + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= '0;
        end else begin
            step <= stepNext;
        end
    end

endmodule

`default_nettype wire

/* hw/xotrSequencer.sv */
// instruction FSM; takes the start strobe, runs the exec steps and ends with a one-cycle done
`timescale 1ns/1ps
`default_nettype none

module xotrSequencer (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic start,
    input  wire logic load,
    input  wire logic lastStep,
    output      logic exec,
    output      logic busy,
    output      logic done,
    output      logic stepClear,
    output      logic stepAdvance,
    output      logic opLatch
);

    xotrPkg::xotrStateE state;
    xotrPkg::xotrStateE stateNext;
    logic               startOk;

    // a load in the same cycle takes priority, start is dropped
    assign startOk = start && !load && (state == xotrPkg::StIdle);

    always_comb begin
        stateNext = state;
        case (state)
            xotrPkg::StIdle: begin
                if (startOk) begin
                    stateNext = xotrPkg::StExec;
                end
            end
            xotrPkg::StExec: begin
                if (lastStep) begin
                    stateNext = xotrPkg::StDone;
                end
            end
            xotrPkg::StDone: begin
                stateNext = xotrPkg::StIdle;
            end
            default: begin
                stateNext = xotrPkg::StIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= xotrPkg::StIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign exec        = (state == xotrPkg::StExec);
    assign busy        = exec;
    assign done        = (state == xotrPkg::StDone);   // single cycle, not held
    assign opLatch     = startOk;
    assign stepClear   = startOk;                      // step 0 on first exec cycle
    assign stepAdvance = exec && !lastStep;

endmodule

`default_nettype wire

/* hw/xotrDecoder.sv */
// latches the opcode class at start and turns class plus step into the control strobes
`timescale 1ns/1ps
`default_nettype none

module xotrDecoder (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          opLatch,
    input  wire logic [7:0]                    opcode,
    input  wire logic                          exec,
    input  wire logic [xotrPkg::StepWidth-1:0] step,
    output      xotrPkg::xotrCtrlS             ctrl
);

    xotrPkg::xotrOpE opClass;
    xotrPkg::xotrOpE opClassNext;
    logic            isReti;

    // ****************************************
    // opcode class
    // ****************************************

    always_comb begin
        opClassNext = xotrPkg::OpNone;
        if (opcode[7:6] == 2'b01 && opcode[2:1] == 2'b10) begin
            opClassNext = opcode[0] ? xotrPkg::OpRet : xotrPkg::OpNeg;  // split on bit 0
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opClass <= xotrPkg::OpNone;
            isReti  <= 1'b0;
        end else if (opLatch) begin
            opClass <= opClassNext;
            isReti  <= (opcode[5:3] == xotrPkg::RetiField);
        end
    end

    // ****************************************
    // strobes
    // ****************************************

    always_comb begin
        ctrl = '0;
        if (exec) begin
            case (opClass)
                xotrPkg::OpNeg: begin
                    ctrl.negWrite = 1'b1;
                    ctrl.lastStep = 1'b1;
                end
                xotrPkg::OpRet: begin
                    if (step == xotrPkg::StepFirst) begin
                        ctrl.popPcLow = 1'b1;
                        ctrl.incSp    = 1'b1;
                    end else begin
                        // second step, or a stray later one ends the op too
                        ctrl.popPcHigh  = (step == xotrPkg::StepSecond);
                        ctrl.incSp      = (step == xotrPkg::StepSecond);
                        ctrl.restoreIff = (step == xotrPkg::StepSecond);
                        ctrl.retiAck    = isReti && (step == xotrPkg::StepSecond);
                        ctrl.lastStep   = 1'b1;
                    end
                end
                default: begin
                    ctrl.lastStep = 1'b1;   // empty step
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/xotrNegAlu.sv */
// combinational NEG datapath; two's complement of A with the full flag byte
`timescale 1ns/1ps
`default_nettype none

module xotrNegAlu (
    input  wire logic [7:0]        a,
    output      logic [7:0]        result,
    output      xotrPkg::xotrFlagS flags
);

    logic aZero;

    assign aZero  = (a == 8'h00);
    assign result = 8'h00 - a;

    always_comb begin
        flags    = '0;                      // b5 and b3 stay clear
        flags.s  = result[7];
        flags.z  = (result == 8'h00);
        flags.h  = (a[3:0] != 4'h0);        // borrow out of low nibble
        flags.pv = (a == 8'h80);            // only overflow case
        flags.n  = 1'b1;
        flags.c  = !aZero;
    end

endmodule

`default_nettype wire

/* hw/xotrRegFile.sv */
// register block for A, F, PC, SP and the IFFs; applies loads, NEG results and stack pops
`timescale 1ns/1ps
`default_nettype none

module xotrRegFile (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              load,
    input  wire xotrPkg::xotrLoadS regLoad,
    input  wire xotrPkg::xotrCtrlS ctrl,
    input  wire logic [7:0]        memData,
    input  wire logic [7:0]        negResult,
    input  wire xotrPkg::xotrFlagS negFlags,
    output      xotrPkg::xotrRegsS regs,
    output      logic [15:0]       memAddr,
    output      logic              memRead
);

    xotrPkg::xotrRegsS regsNext;
    logic              ctrlActive;
    logic              doneCycle;   // high in the cycle after the last step

    // every exec step raises at least one strobe
    assign ctrlActive = |ctrl;

    // ****************************************
    // next state
    // ****************************************

    always_comb begin
        regsNext = regs;
        if (load && !ctrlActive && !doneCycle) begin
            regsNext.a    = regLoad.a;
            regsNext.sp   = regLoad.sp;
            regsNext.pc   = regLoad.pc;
            regsNext.iff2 = regLoad.iff2;
            regsNext.iff1 = 1'b0;           // F untouched
        end else begin
            if (ctrl.negWrite) begin
                regsNext.a = negResult;
                regsNext.f = negFlags;
            end
            if (ctrl.popPcLow) begin
                regsNext.pc[7:0] = memData;
            end
            if (ctrl.popPcHigh) begin
                regsNext.pc[15:8] = memData;
            end
            if (ctrl.incSp) begin
                regsNext.sp = regs.sp + 16'd1;
            end
            if (ctrl.restoreIff) begin
                regsNext.iff1 = regs.iff2;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs      <= '0;
            doneCycle <= 1'b0;
        end else begin
            regs      <= regsNext;
            doneCycle <= ctrl.lastStep;
        end
    end

    // ****************************************
    // stack read port
    // ****************************************

    assign memAddr = regs.sp;
    assign memRead = ctrl.popPcLow || ctrl.popPcHigh;

endmodule

`default_nettype wire

/* hw/xotrCore.sv */
// top level of the ED 01xxx10x unit; connects sequencer, step counter, decoder, NEG and registers
`timescale 1ns/1ps
`default_nettype none

module xotrCore (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              start,
    input  wire logic [7:0]        opcode,
    input  wire logic              load,
    input  wire xotrPkg::xotrLoadS regLoad,
    input  wire logic [7:0]        memData,
    output      logic              busy,
    output      logic              done,
    output      logic              retiAck,
    output      logic [15:0]       memAddr,
    output      logic              memRead,
    output      xotrPkg::xotrRegsS regs
);

    logic                          exec;
    logic                          stepClear;
    logic                          stepAdvance;
    logic                          opLatch;
    logic [xotrPkg::StepWidth-1:0] step;
    xotrPkg::xotrCtrlS             ctrl;
    logic [7:0]                    negResult;
    xotrPkg::xotrFlagS             negFlags;

    xotrSequencer sequencer (
        .clk(clk), .rstN(rstN), .start(start), .load(load),
        .lastStep(ctrl.lastStep), .exec(exec), .busy(busy), .done(done),
        .stepClear(stepClear), .stepAdvance(stepAdvance), .opLatch(opLatch)
    );

    xotrStepCounter stepCounter (
        .clk(clk), .rstN(rstN), .clear(stepClear), .advance(stepAdvance), .step(step)
    );

    xotrDecoder decoder (
        .clk(clk), .rstN(rstN), .opLatch(opLatch), .opcode(opcode),
        .exec(exec), .step(step), .ctrl(ctrl)
    );

    xotrNegAlu negAlu (
        .a(regs.a), .result(negResult), .flags(negFlags)
    );

    xotrRegFile regFile (
        .clk(clk), .rstN(rstN), .load(load), .regLoad(regLoad), .ctrl(ctrl),
        .memData(memData), .negResult(negResult), .negFlags(negFlags),
        .regs(regs), .memAddr(memAddr), .memRead(memRead)
    );

    assign retiAck = ctrl.retiAck;  // to interrupt controller

endmodule

`default_nettype wire

/* dv/xotrCore_checker.sv */
// timing assertions on the xotrCore strobes; attached to the top level by the bind below
`timescale 1ns/1ps
`default_nettype none

module xotrCore_checker (
    input wire logic        clk,
    input wire logic        rstN,
    input wire logic        opLatch,
    input wire logic        exec,
    input wire logic        lastStep,
    input wire logic        busy,
    input wire logic        done,
    input wire logic        retiAck,
    input wire logic        memRead
);

    int         failCount = 0;
    logic       pending;        // accepted start still waiting for done
    logic [1:0] readCount;      // stack reads of the running op

    task automatic noteFailure(input string what);
        failCount++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending   <= 1'b0;
            readCount <= '0;
        end else if (opLatch) begin
            pending   <= 1'b1;
            readCount <= '0;
        end else begin
            if (done) begin
                pending <= 1'b0;
            end
            if (memRead) begin
                readCount <= readCount + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) !rstN |-> !busy && !done && !retiAck && !memRead)
        else noteFailure("outputs not idle during reset");
    assert property (@(posedge clk) disable iff (!rstN) opLatch |=> busy)
        else noteFailure("accepted start did not raise busy");
    assert property (@(posedge clk) disable iff (!rstN) done |-> pending && !opLatch)
        else noteFailure("done without an accepted start");
    assert property (@(posedge clk) disable iff (!rstN) opLatch |-> !pending)
        else noteFailure("start accepted before the previous done");
    assert property (@(posedge clk) disable iff (!rstN) memRead |-> exec)
        else noteFailure("stack read outside exec");
    assert property (@(posedge clk) disable iff (!rstN) exec && !lastStep |-> memRead)
        else noteFailure("first RET step did not read the stack");
    assert property (@(posedge clk) disable iff (!rstN) exec && !lastStep |=> memRead)
        else noteFailure("second RET step did not read the stack");
    assert property (@(posedge clk) disable iff (!rstN)
        done |-> readCount == 2'd0 || readCount == 2'd2)
        else noteFailure("op did not read zero or two stack bytes");
    assert property (@(posedge clk) disable iff (!rstN) retiAck |-> exec && lastStep && memRead)
        else noteFailure("retiAck outside the last RET step");

endmodule

bind xotrCore xotrCore_checker timingChecker (
    .clk(clk), .rstN(rstN), .opLatch(opLatch), .exec(exec), .lastStep(ctrl.lastStep),
    .busy(busy), .done(done), .retiAck(retiAck), .memRead(memRead)
);

`default_nettype wire

/* dv/xotrCore_tb.sv */
// testbench for xotrCore; random loads and ED opcodes checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module xotrCore_tb;

    localparam int NumTrans    = 200;
    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 5;
    localparam int TimeoutNs   = (NumTrans * 5 + 50) * ClkPeriod;
    localparam int Seed        = 32'hd4d5_8a12;

    logic              clk;
    logic              rstN;
    logic              start;
    logic [7:0]        opcode;
    logic              load;
    xotrPkg::xotrLoadS regLoad;
    logic [7:0]        memData;
    logic              busy;
    logic              done;
    logic              retiAck;
    logic [15:0]       memAddr;
    logic              memRead;
    xotrPkg::xotrRegsS regs;

    logic [7:0]        stackMem [256];
    xotrPkg::xotrRegsS expRegs;         // reference model state
    int                errCount = 0;
    int                assertFails;

    assign memData = stackMem[memAddr[7:0]];   // combinational stack read

    xotrCore xotrCore_inst (
        .clk(clk), .rstN(rstN), .start(start), .opcode(opcode), .load(load),
        .regLoad(regLoad), .memData(memData), .busy(busy), .done(done),
        .retiAck(retiAck), .memAddr(memAddr), .memRead(memRead), .regs(regs)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // ****************************************
    // reference model and stimulus
    // ****************************************

    function automatic xotrPkg::xotrRegsS modelOp(input xotrPkg::xotrRegsS r,
                                                  input logic [7:0] op);
        xotrPkg::xotrRegsS n;
        logic [7:0]        neg;
        n   = r;
        neg = ~r.a + 8'd1;                       // two's complement
        if (op[7:6] == 2'b01 && op[2:0] == 3'b100) begin
            n.a    = neg;
            n.f    = '0;
            n.f.s  = neg[7];
            n.f.z  = (neg == 8'h00);
            n.f.h  = (r.a[3:0] != 4'h0);
            n.f.pv = (r.a == 8'h80);
            n.f.n  = 1'b1;
            n.f.c  = (r.a != 8'h00);
        end else if (op[7:6] == 2'b01 && op[2:0] == 3'b101) begin
            n.pc   = {stackMem[8'(r.sp + 16'd1)], stackMem[r.sp[7:0]]};  // low byte first
            n.sp   = r.sp + 16'd2;
            n.iff1 = r.iff2;
        end
        return n;
    endfunction

    function automatic logic [7:0] pickOpcode();
        logic [2:0] mid;
        int         pick;
        mid  = 3'($urandom);
        pick = $urandom_range(3);
        case (pick)
            0: return {2'b01, mid, 3'b100};
            1: return {2'b01, mid, 3'b101};
            2: return 8'h4d;                     // RETI
            default: return 8'($urandom);
        endcase
    endfunction

    function automatic xotrPkg::xotrLoadS pickLoad();
        xotrPkg::xotrLoadS ld;
        int                pick;
        pick    = $urandom_range(3);
        ld.a    = (pick == 0) ? 8'h00 : (pick == 1) ? 8'h80 : 8'($urandom);
        ld.sp   = 16'($urandom);
        ld.pc   = 16'($urandom);
        ld.iff2 = 1'($urandom);
        return ld;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        assert (exp === act) else begin
            errCount++;
            $display("** Error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic compareRegs();
        checkValue("regs.a", expRegs.a, regs.a);
        checkValue("regs.f", expRegs.f, regs.f);
        checkValue("regs.pc", expRegs.pc, regs.pc);
        checkValue("regs.sp", expRegs.sp, regs.sp);
        checkValue("regs.iff1", expRegs.iff1, regs.iff1);
        checkValue("regs.iff2", expRegs.iff2, regs.iff2);
    endtask

    task automatic applyLoad(input logic withStart);
        xotrPkg::xotrLoadS ld;
        ld = pickLoad();
        @(posedge clk);
        load    <= 1'b1;
        regLoad <= ld;
        start   <= withStart;                    // dropped in favour of the load
        opcode  <= pickOpcode();
        @(posedge clk);
        load  <= 1'b0;
        start <= 1'b0;
        expRegs.a    = ld.a;
        expRegs.sp   = ld.sp;
        expRegs.pc   = ld.pc;
        expRegs.iff2 = ld.iff2;
        expRegs.iff1 = 1'b0;
        @(negedge clk);
        compareRegs();
        checkValue("busy", 16'd0, busy);
    endtask

    task automatic runOp(input logic [7:0] op, input logic junk);
        int   cycles;
        int   acks;
        logic isRet;
        isRet   = (op[7:6] == 2'b01 && op[2:0] == 3'b101);
        expRegs = modelOp(expRegs, op);
        @(posedge clk);
        start  <= 1'b1;
        opcode <= op;
        @(posedge clk);                          // start edge
        start   <= junk;                         // held through exec and done, must be ignored
        load    <= junk && ($urandom_range(1) == 1);
        regLoad <= pickLoad();
        opcode  <= pickOpcode();
        cycles = 0;
        acks   = 0;
        do begin
            @(negedge clk);
            cycles++;
            acks += retiAck;
        end while (!done && cycles < 8);
        checkValue("done cycles", isRet ? 16'd3 : 16'd2, 16'(cycles));
        checkValue("retiAck pulses", 16'(isRet && op[5:3] == 3'b001), 16'(acks));
        @(posedge clk);                          // leaves the done state
        start <= 1'b0;
        load  <= 1'b0;
        @(negedge clk);
        compareRegs();
    endtask

    // ****************************************
    // main sequence and watchdog
    // ****************************************

    initial begin
        void'($urandom(Seed));
        clk     = 1'b0;
        rstN    = 1'b0;
        start   = 1'b0;
        load    = 1'b0;
        opcode  = 8'h00;
        regLoad = '0;
        expRegs = '0;
        for (int i = 0; i < 256; i++) begin
            stackMem[i] = 8'($urandom);
        end
        repeat (ResetCycles - 1) @(posedge clk);
        @(negedge clk);
        checkValue("busy", 16'd0, busy);
        checkValue("done", 16'd0, done);
        checkValue("retiAck", 16'd0, retiAck);
        checkValue("memRead", 16'd0, memRead);
        compareRegs();
        @(posedge clk);
        rstN <= 1'b1;
        applyLoad(1'b0);
        for (int i = 0; i < NumTrans; i++) begin
            if ($urandom_range(2) == 0) begin
                applyLoad($urandom_range(3) == 0);
            end else begin
                runOp(pickOpcode(), $urandom_range(3) == 0);
            end
        end
        repeat (2) @(posedge clk);
        assertFails = xotrCore_inst.timingChecker.failCount;
        $display("value errors: %0d, assertion failures: %0d", errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("timeout: the test sequence did not finish within %0d ns", TimeoutNs);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* xotrCore.f */
hw/xotrPkg.sv
hw/xotrStepCounter.sv
hw/xotrSequencer.sv
hw/xotrDecoder.sv
hw/xotrNegAlu.sv
hw/xotrRegFile.sv
hw/xotrCore.sv
dv/xotrCore_checker.sv
dv/xotrCore_tb.sv

/* Makefile */
# Verilator build and run for the xotrCore testbench

TOP := xotrCore_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f xotrCore.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
